// File: tb.f
design/booth_pkg.sv
design/booth_ctrl_if.sv
design/booth_controller.sv
design/booth_datapath.sv
design/booth_multiplier.sv
verification/tb_clock_gen.sv
verification/booth_multiplier_asserts.sv
verification/tb_booth_multiplier.sv

// File: Bender.yml
package:
  name: booth_multiplier

sources:
  # Synthesizable design, package first
  - files:
      - design/booth_pkg.sv
      - design/booth_ctrl_if.sv
      - design/booth_controller.sv
      - design/booth_datapath.sv
      - design/booth_multiplier.sv

  # Simulation only
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/booth_multiplier_asserts.sv
      - verification/tb_booth_multiplier.sv

// File: verification/tb_booth_multiplier.sv
module tb_booth_multiplier;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WIDTH        = 8;
    localparam int PW           = 2 * WIDTH;
    localparam int NUM_OPS      = 400;
    localparam int STALL_PCT    = 30;  // Chance the sink holds off in a cycle
    localparam int GAP_PCT      = 25;  // Chance of idle cycles before a pair
    localparam int WAIT_TIMEOUT = 200; // Cycles allowed for any single wait
    localparam int SEED         = 61799;

    logic             clk;
    logic             rst_n;
    logic             src_valid;
    logic [WIDTH-1:0] multiplicand;
    logic [WIDTH-1:0] multiplier;
    logic             src_ready;
    logic             dest_valid;
    logic             dest_ready;
    logic [PW-1:0]    product;

    logic [PW-1:0] exp_q[$];           // Model products in acceptance order
    int            accept_q[$];        // Edge number of each accepted pair
    int            errors          = 0;
    int            timeouts        = 0;
    int            accepted        = 0;
    int            delivered       = 0;
    int            cycle           = 0;
    bit            stop_stall      = 1'b0;
    logic          prev_dest_valid = 1'b0;
    logic          prev_stalled    = 1'b0;
    logic [PW-1:0] held_product;
    logic [PW-1:0] expected;
    int            latency;

    tb_clock_gen clk_gen (.clk(clk), .rst_n(rst_n));

    booth_multiplier #(.WIDTH(WIDTH)) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .src_valid    (src_valid),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .src_ready    (src_ready),
        .dest_valid   (dest_valid),
        .dest_ready   (dest_ready),
        .product      (product)
    );

    function automatic logic [PW-1:0] signed_product(input logic [WIDTH-1:0] a,
                                                     input logic [WIDTH-1:0] b);
        int sa;
        int sb;
        sa = $signed(a);
        sb = $signed(b);
        return PW'(sa * sb);
    endfunction

    task automatic report_mismatch(input string name, input logic [PW-1:0] exp_val,
                                   input logic [PW-1:0] got_val);
        errors++;
        $display("ERR %0t %s expected %h got %h", $time, name, exp_val, got_val);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    // Model and checker, sampled on the rising edge
    always @(posedge clk) begin
        if (rst_n) begin
            cycle++;
            if (src_valid && src_ready) begin
                exp_q.push_back(signed_product(multiplicand, multiplier));
                accept_q.push_back(cycle);
                accepted++;
            end
            // First high sample, so dest_valid rose after the previous edge
            if (dest_valid && !prev_dest_valid) begin
                assert (accept_q.size() > 0)
                    else report_failure("dest_valid rose with no pair outstanding");
                if (accept_q.size() > 0) begin
                    latency = cycle - 1 - accept_q.pop_front();
                    assert (latency == WIDTH + 1)
                        else report_failure($sformatf("dest_valid rose %0d edges after accept",
                                                      latency));
                end
            end
            if (dest_valid && dest_ready) begin
                delivered++;
                assert (exp_q.size() > 0)
                    else report_failure("product delivered with no pair outstanding");
                if (exp_q.size() > 0) begin
                    expected = exp_q.pop_front();
                    assert (product === expected)
                        else report_mismatch("product", expected, product);
                end
            end
            if (prev_stalled) begin
                assert (dest_valid) else report_failure("dest_valid dropped during a stall");
                assert (product === held_product)
                    else report_mismatch("product", held_product, product);
            end
            if (dest_valid && !dest_ready) begin
                assert (src_ready === 1'b0) else report_mismatch("src_ready", '0, PW'(src_ready));
            end
            prev_stalled    = dest_valid && !dest_ready;
            held_product    = product;
            prev_dest_valid = dest_valid;
        end
    end

    task automatic wait_reset();
        int waited;
        waited = 0;
        while (!rst_n && waited < WAIT_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (!rst_n) begin
            timeouts++;
            $display("Timeout at %0t: reset was never released", $time);
        end
    endtask

    // Holds the pair until the DUT takes it, returns just after that edge
    task automatic send_pair(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
        int waited;
        bit taken;
        waited       = 0;
        taken        = 1'b0;
        src_valid    = 1'b1;
        multiplicand = a;
        multiplier   = b;
        while (!taken && waited < WAIT_TIMEOUT) begin
            @(posedge clk);
            taken = src_ready;
            waited++;
        end
        if (!taken) begin
            timeouts++;
            $display("Timeout at %0t: operand pair was never accepted", $time);
        end
    endtask

    task automatic drive_pairs();
        logic [WIDTH-1:0] corner [5];
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        int               gap;
        corner = '{8'h80, 8'hff, 8'h00, 8'h01, 8'h7f}; // -128, -1, 0, 1, 127
        for (int i = 0; i < NUM_OPS && timeouts == 0; i++) begin
            if (i < 25) begin
                a = corner[i / 5]; // Every corner pairing first
                b = corner[i % 5];
            end else begin
                a = WIDTH'($urandom);
                b = WIDTH'($urandom);
            end
            @(negedge clk);
            if ($urandom_range(99) < GAP_PCT) begin
                gap       = $urandom_range(1, 4);
                src_valid = 1'b0;
                repeat (gap) @(negedge clk);
            end
            send_pair(a, b);
        end
        @(negedge clk);
        src_valid = 1'b0;
    endtask

    task automatic drive_stall();
        while (!stop_stall) begin
            @(negedge clk);
            dest_ready = ($urandom_range(99) >= STALL_PCT);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (delivered < NUM_OPS && waited < WAIT_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (delivered < NUM_OPS) begin
            timeouts++;
            $display("Timeout at %0t: not all products were delivered", $time);
        end
    endtask

    task automatic finish_run();
        $display("Accepted %0d, delivered %0d, errors %0d, timeouts %0d",
                 accepted, delivered, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    initial begin
        src_valid    = 1'b0;
        multiplicand = '0;
        multiplier   = '0;
        dest_ready   = 1'b0;
        void'($urandom(SEED));
        wait_reset();
        if (timeouts == 0) begin
            fork
                drive_stall();
            join_none
            drive_pairs();
        end
        if (timeouts == 0) begin
            wait_drain();
        end
        stop_stall = 1'b1;
        if (timeouts == 0) begin
            // No lost or duplicated results, also across overlapped handshakes
            assert (accepted == NUM_OPS && delivered == accepted && exp_q.size() == 0
                    && accept_q.size() == 0)
                else report_failure("accepted pairs and delivered products do not match");
        end
        finish_run();
    end

endmodule

// File: verification/booth_multiplier_asserts.sv
module booth_multiplier_asserts #(
    parameter int WIDTH = booth_pkg::DEFAULT_WIDTH
) (
    input logic               clk,
    input logic               rst_n,
    input logic               src_valid,
    input logic               src_ready,
    input logic [WIDTH-1:0]   multiplicand,
    input logic [WIDTH-1:0]   multiplier,
    input logic               dest_valid,
    input logic               dest_ready,
    input logic [2*WIDTH-1:0] product
);
    timeunit 1ns;
    timeprecision 100ps;

    // Idle handshake while reset is held
    reset_idle: assert property (@(posedge clk) !rst_n |-> !dest_valid && src_ready)
        else $error("Handshake outputs not idle during reset");

    // Still idle on the first edge after release
    reset_exit: assert property (@(posedge clk) !rst_n |=> !dest_valid && src_ready)
        else $error("Handshake outputs not idle right after reset");

    src_hold: assert property (@(posedge clk) disable iff (!rst_n)
        src_valid && !src_ready |=> src_valid && $stable(multiplicand) && $stable(multiplier))
        else $error("Source valid or operands changed before the transfer");

    dest_hold: assert property (@(posedge clk) disable iff (!rst_n)
        dest_valid && !dest_ready |=> dest_valid && $stable(product))
        else $error("Destination valid or product changed before the transfer");

    // No new operands while the result is stuck
    stall_blocks_src: assert property (@(posedge clk) disable iff (!rst_n)
        dest_valid && !dest_ready |-> !src_ready)
        else $error("Source ready raised while the sink stalls");

endmodule

bind booth_multiplier booth_multiplier_asserts #(.WIDTH(WIDTH)) u_asserts (
    .clk          (clk),
    .rst_n        (rst_n),
    .src_valid    (src_valid),
    .src_ready    (src_ready),
    .multiplicand (multiplicand),
    .multiplier   (multiplier),
    .dest_valid   (dest_valid),
    .dest_ready   (dest_ready),
    .product      (product)
);

// File: verification/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk; // 8 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1; // Released away from the sampling edge
    end

endmodule

// File: design/booth_multiplier.sv
module booth_multiplier #(
    parameter int WIDTH = booth_pkg::DEFAULT_WIDTH
) (
    input  logic               clk,
    input  logic               rst_n,

    // Operand handshake
    input  logic               src_valid,
    input  logic [WIDTH-1:0]   multiplicand,
    input  logic [WIDTH-1:0]   multiplier,
    output logic               src_ready,

    // Product handshake
    output logic               dest_valid,
    input  logic               dest_ready,
    output logic [2*WIDTH-1:0] product
);

    booth_ctrl_if ctrl_bus ();

    booth_controller u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .src_valid  (src_valid),
        .src_ready  (src_ready),
        .dest_valid (dest_valid),
        .dest_ready (dest_ready),
        .bus        (ctrl_bus.ctrl)
    );

    booth_datapath #(
        .WIDTH (WIDTH)
    ) u_dp (
        .clk          (clk),
        .rst_n        (rst_n),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .product      (product),
        .bus          (ctrl_bus.dp)
    );

endmodule

// File: design/booth_datapath.sv
module booth_datapath #(
    parameter int WIDTH = booth_pkg::DEFAULT_WIDTH
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [WIDTH-1:0]     multiplicand,
    input  logic [WIDTH-1:0]     multiplier,
    output logic [2*WIDTH-1:0]   product,
    booth_ctrl_if.dp             bus
);
    import booth_pkg::*;

    localparam int CNT_W = $clog2(WIDTH) + 1;

    typedef logic [WIDTH-1:0]   operand_t;
    typedef logic [WIDTH:0]     acc_t;     // One guard bit above the operand width
    typedef logic [2*WIDTH-1:0] product_t;
    typedef logic [CNT_W-1:0]   count_t;

    acc_t     a_reg;     // Accumulator
    operand_t q_reg;     // Multiplier, shifted out from the LSB
    logic     q_1_reg;   // Bit shifted out of Q last iteration
    operand_t m_reg;     // Multiplicand
    count_t   count;     // Iterations still to run
    product_t prod_reg;

    acc_t     m_ext;     // Sign-extended multiplicand
    acc_t     alu_res;   // A after add/sub, before shift

    assign m_ext = {m_reg[WIDTH-1], m_reg};

    always_comb begin
        case (bus.alu_op)
            ALU_ADD: alu_res = a_reg + m_ext;
            ALU_SUB: alu_res = a_reg - m_ext;
            default: alu_res = a_reg;
        endcase
    end

    // Operand and iteration registers
    always_ff @(posedge clk) begin
        if (bus.load) begin
            a_reg   <= '0;
            q_reg   <= multiplier;
            q_1_reg <= 1'b0;
            m_reg   <= multiplicand;
        end else if (bus.step) begin
            // Arithmetic shift right of {A, Q, Q_1}
            a_reg   <= {alu_res[WIDTH], alu_res[WIDTH:1]};
            q_reg   <= {alu_res[0], q_reg[WIDTH-1:1]};
            q_1_reg <= q_reg[0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (bus.load) begin
            count <= count_t'(WIDTH);
        end else if (bus.step) begin
            count <= count - 1'b1;
        end
    end

    // Result held until the next capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_reg <= '0;
        end else if (bus.capture) begin
            prod_reg <= {a_reg[WIDTH-1:0], q_reg}; // Guard bit is only a sign copy here
        end
    end

    assign product        = prod_reg;
    assign bus.q0         = q_reg[0];
    assign bus.q_1        = q_1_reg;
    assign bus.count_done = (count == '0);

endmodule

// File: design/booth_controller.sv
module booth_controller (
    input  logic clk,
    input  logic rst_n,
    input  logic src_valid,  // Operand pair offered
    output logic src_ready,  // Able to take a new operand pair
    output logic dest_valid, // Product available
    input  logic dest_ready, // Sink takes the product
    booth_ctrl_if.ctrl bus
);
    import booth_pkg::*;

    typedef enum logic [1:0] {
        IDLE = 2'b00, // Waiting for operands
        RUN  = 2'b01, // Booth iterations, then capture
        DONE = 2'b10  // Holding product for the sink
    } state_t;

    state_t  state;
    state_t  next_state;
    alu_op_t booth_op;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Booth recoding of the current LSB pair
    always_comb begin
        case ({bus.q0, bus.q_1})
            2'b10:   booth_op = ALU_SUB; // Entering a run of ones
            2'b01:   booth_op = ALU_ADD; // Leaving a run of ones
            default: booth_op = ALU_NOP; // Inside a run
        endcase
    end

    always_comb begin
        next_state  = state;
        src_ready   = 1'b0;
        dest_valid  = 1'b0;
        bus.load    = 1'b0;
        bus.step    = 1'b0;
        bus.capture = 1'b0;
        bus.alu_op  = ALU_NOP;

        case (state)
            IDLE: begin
                src_ready = 1'b1;
                if (src_valid) begin
                    bus.load   = 1'b1; // Operands taken on this edge
                    next_state = RUN;
                end
            end

            RUN: begin
                if (bus.count_done) begin
                    // All WIDTH iterations done, latch the result
                    bus.capture = 1'b1;
                    next_state  = DONE;
                end else begin
                    bus.step   = 1'b1;
                    bus.alu_op = booth_op;
                end
            end

            DONE: begin
                dest_valid = 1'b1;
                if (dest_ready) begin
                    // Result leaves now, so a new pair may enter on the same edge
                    src_ready = 1'b1;
                    if (src_valid) begin
                        bus.load   = 1'b1;
                        next_state = RUN;
                    end else begin
                        next_state = IDLE;
                    end
                end
            end

            default: begin
                next_state = IDLE; // Recover from an illegal encoding
            end
        endcase
    end

endmodule

// File: design/booth_ctrl_if.sv
interface booth_ctrl_if;
    import booth_pkg::*;

    logic    load;       // Capture operands and init iteration state
    logic    step;       // One Booth iteration
    alu_op_t alu_op;     // Operation for this iteration
    logic    capture;    // Copy A and Q into product register

    logic    q0;         // LSB of Q
    logic    q_1;        // Extra bit right of Q
    logic    count_done; // Iteration counter at zero

    modport ctrl (
        output load, step, alu_op, capture,
        input  q0, q_1, count_done
    );

    modport dp (
        input  load, step, alu_op, capture,
        output q0, q_1, count_done
    );

endinterface

// File: design/booth_pkg.sv
package booth_pkg;

    // Operand width used when the top level does not override it
    localparam int DEFAULT_WIDTH = 8;

    // Operation applied to the accumulator ahead of the arithmetic shift
    typedef logic [1:0] alu_op_t;

    localparam alu_op_t ALU_NOP = 2'b00; // Keep A
    localparam alu_op_t ALU_SUB = 2'b01; // A minus M
    localparam alu_op_t ALU_ADD = 2'b10; // A plus M

    // Booth pair {Q0, Q_1} selects the operation:
    //   10 starts a run of ones, so M is subtracted
    //   01 ends a run of ones, so M is added
    //   00 and 11 are inside a run and leave A alone

endpackage
